// ==== design/periph_pkg.sv ====
package periph_pkg;

   // Peripheral byte address window is 12 bits wide
   localparam int periph_addr_msb = 11;

   // Address bits 11 down to 8 pick the peripheral
   localparam int region_lsb = 8;

   // Region codes
   // Anything not listed is an unmapped hole
   typedef enum logic [3:0] {
      region_gpio  = 4'd0,
      region_timer = 4'd1
   } periph_region_t;

   // GPIO word offsets, taken from address bits 3 down to 2
   localparam logic [1:0] gpio_reg_out = 2'd0;
   localparam logic [1:0] gpio_reg_in  = 2'd1;

   // Timer word offsets
   localparam logic [1:0] timer_reg_load   = 2'd0;
   localparam logic [1:0] timer_reg_ctrl   = 2'd1;
   localparam logic [1:0] timer_reg_count  = 2'd2;
   localparam logic [1:0] timer_reg_status = 2'd3;

   // Timer FSM states
   // Idle holds the counter, run decrements it,
   // expired parks after a one-shot reaches zero
   typedef enum logic [1:0] {
      tmr_idle    = 2'd0,
      tmr_run     = 2'd1,
      tmr_expired = 2'd2
   } timer_state_t;

endpackage

// ==== design/periph_bus_decoder.sv ====
`timescale 1ns/1ps

module periph_bus_decoder (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic [periph_pkg::periph_addr_msb:0] bus_addr,
   input  logic                               bus_en,
   input  logic [31:0]                        gpio_rdata,
   input  logic [31:0]                        timer_rdata,
   output logic                               gpio_en,
   output logic                               timer_en,
   output logic [31:0]                        bus_dout
);

   import periph_pkg::*;

   // Region field of the current address
   periph_region_t region;

   // Read data picked for the current access
   logic [31:0] rdata_sel;

   // Upper address bits name the peripheral
   assign region = periph_region_t'(bus_addr[periph_addr_msb:region_lsb]);

   // Peripheral enables
   // At most one is high, and only while the bus strobe is up
   always_comb begin
      gpio_en  = 1'b0;
      timer_en = 1'b0;
      if (bus_en) begin
         case (region)
            region_gpio: begin
               gpio_en = 1'b1;
            end
            region_timer: begin
               timer_en = 1'b1;
            end
            default: begin
               // Unmapped hole, nobody answers
               gpio_en  = 1'b0;
               timer_en = 1'b0;
            end
         endcase
      end
   end

   // Read mux by region
   // Unmapped regions read back as zero
   always_comb begin
      case (region)
         region_gpio: begin
            rdata_sel = gpio_rdata;
         end
         region_timer: begin
            rdata_sel = timer_rdata;
         end
         default: begin
            rdata_sel = 32'h0;
         end
      endcase
   end

   // Registered read data
   // Captured at the end of every access, writes included,
   // so a write returns the register value from before it
   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         bus_dout <= 32'h0;
      end
      else begin
         if (bus_en) begin
            bus_dout <= rdata_sel;
         end
         // Otherwise hold until the next access
      end
   end

endmodule

// ==== design/gpio_ctrl.sv ====
`timescale 1ns/1ps

module gpio_ctrl #(
   parameter int gpio_width = 32
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic [periph_pkg::periph_addr_msb:0] bus_addr,
   input  logic [3:0]                         bus_bytesel,
   input  logic [31:0]                        bus_din,
   input  logic                               gpio_en,
   input  logic [gpio_width-1:0]              pad_gpio_in,
   output logic [31:0]                        gpio_rdata,
   output logic [gpio_width-1:0]              gpio_pad_out
);

   import periph_pkg::*;

   // Output register and two-stage input synchronizer
   logic [gpio_width-1:0] gpio_out_r;
   logic [gpio_width-1:0] gpio_in_m;
   logic [gpio_width-1:0] gpio_in_r;

   // Output register after the byte-lane merge, on a full word
   logic [31:0] out_merged;

   logic [1:0] offset;
   logic       out_wr;

   assign offset = bus_addr[3:2];

   // Any byte select makes it a write
   assign out_wr = gpio_en && (|bus_bytesel) && (offset == gpio_reg_out);

   // Merge selected lanes into the current value
   // Lanes above gpio_width drop off when truncated below
   always_comb begin
      out_merged = 32'(gpio_out_r);
      for (int b = 0; b < 4; b++) begin
         if (bus_bytesel[b]) begin
            out_merged[b*8 +: 8] = bus_din[b*8 +: 8];
         end
      end
   end

   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         gpio_in_m  <= '0;
         gpio_in_r  <= '0;
         gpio_out_r <= '0;
      end
      else begin
         // Pads are asynchronous, resync them through two flops
         gpio_in_m <= pad_gpio_in;
         gpio_in_r <= gpio_in_m;
         if (out_wr) begin
            gpio_out_r <= out_merged[gpio_width-1:0];
         end
      end
   end

   // Register read mux, zero-extended to the bus width
   always_comb begin
      case (offset)
         gpio_reg_out: gpio_rdata = 32'(gpio_out_r);
         gpio_reg_in:  gpio_rdata = 32'(gpio_in_r);
         default:      gpio_rdata = 32'h0;
      endcase
   end

   assign gpio_pad_out = gpio_out_r;

endmodule

// ==== design/timer_ctrl.sv ====
`timescale 1ns/1ps

module timer_ctrl #(
   parameter int timer_width = 32
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic [periph_pkg::periph_addr_msb:0] bus_addr,
   input  logic [3:0]                         bus_bytesel,
   input  logic [31:0]                        bus_din,
   input  logic                               timer_en,
   output logic [31:0]                        timer_rdata,
   output logic                               timer_irq
);

   import periph_pkg::*;

   // Reload value and live counter
   logic [timer_width-1:0] load_r;
   logic [timer_width-1:0] count_r;

   // Control bits
   // Bit 0 enable, bit 1 auto-reload
   logic enable_r;
   logic auto_r;

   // Sticky expiry flag, drives the irq level
   logic flag_r;

   timer_state_t state_r;

   logic [1:0] offset;
   logic       wr;
   logic       load_wr;
   logic       ctrl_wr;
   logic       status_wr;

   assign offset = bus_addr[3:2];
   assign wr     = timer_en && (|bus_bytesel);

   // Timer registers take the whole word on any write
   assign load_wr   = wr && (offset == timer_reg_load);
   assign ctrl_wr   = wr && (offset == timer_reg_ctrl);
   assign status_wr = wr && (offset == timer_reg_status);

   // Reload register
   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         load_r <= '0;
      end
      else if (load_wr) begin
         load_r <= bus_din[timer_width-1:0];
      end
   end

   // Control bits, counter, flag and FSM
   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         enable_r <= 1'b0;
         auto_r   <= 1'b0;
         count_r  <= '0;
         flag_r   <= 1'b0;
         state_r  <= tmr_idle;
      end
      else begin
         // Status write clears the flag
         // A zero count on the same edge sets it again below
         if (status_wr) begin
            flag_r <= 1'b0;
         end

         if (ctrl_wr) begin
            enable_r <= bus_din[0];
            auto_r   <= bus_din[1];
            if (bus_din[0]) begin
               // Start or restart from the reload value
               count_r <= load_r;
               state_r <= tmr_run;
            end
            else begin
               state_r <= tmr_idle;
            end
         end
         else begin
            case (state_r)
               tmr_run: begin
                  if (count_r == '0) begin
                     flag_r <= 1'b1;
                     if (auto_r) begin
                        count_r <= load_r;
                     end
                     else begin
                        state_r <= tmr_expired;
                     end
                  end
                  else begin
                     count_r <= count_r - 1'b1;
                  end
               end
               tmr_expired: begin
                  // Parked until the control register is written
                  state_r <= tmr_expired;
               end
               default: begin
                  // Idle, counter holds its value
                  state_r <= tmr_idle;
               end
            endcase
         end
      end
   end

   // Register read mux
   // Status shows flag in bit 0 and state in bits 3 to 2
   always_comb begin
      case (offset)
         timer_reg_load:   timer_rdata = 32'(load_r);
         timer_reg_ctrl:   timer_rdata = {30'h0, auto_r, enable_r};
         timer_reg_count:  timer_rdata = 32'(count_r);
         timer_reg_status: timer_rdata = {28'h0, state_r, 1'b0, flag_r};
         default:          timer_rdata = 32'h0;
      endcase
   end

   assign timer_irq = flag_r;

endmodule

// ==== design/periph_top.sv ====
`timescale 1ns/1ps

module periph_top #(
   parameter int gpio_width  = 32,
   parameter int timer_width = 32
) (
   input  logic                               clk,
   input  logic                               rst_n,
   // Core data bus, one-cycle strobe access
   input  logic [periph_pkg::periph_addr_msb:0] bus_addr,
   input  logic [3:0]                         bus_bytesel,
   input  logic [31:0]                        bus_din,
   input  logic                               bus_en,
   output logic [31:0]                        bus_dout,
   // Pads
   input  logic [gpio_width-1:0]              pad_gpio_in,
   output logic [gpio_width-1:0]              gpio_pad_out,
   // Interrupt level to the core
   output logic                               timer_irq
);

   // Per-peripheral strobes
   logic gpio_en;
   logic timer_en;

   // Combinational read data back to the decoder
   logic [31:0] gpio_rdata;
   logic [31:0] timer_rdata;

   periph_bus_decoder u_decoder (
      .clk         (clk),
      .rst_n       (rst_n),
      .bus_addr    (bus_addr),
      .bus_en      (bus_en),
      .gpio_rdata  (gpio_rdata),
      .timer_rdata (timer_rdata),
      .gpio_en     (gpio_en),
      .timer_en    (timer_en),
      .bus_dout    (bus_dout)
   );

   gpio_ctrl #(
      .gpio_width (gpio_width)
   ) u_gpio (
      .clk          (clk),
      .rst_n        (rst_n),
      .bus_addr     (bus_addr),
      .bus_bytesel  (bus_bytesel),
      .bus_din      (bus_din),
      .gpio_en      (gpio_en),
      .pad_gpio_in  (pad_gpio_in),
      .gpio_rdata   (gpio_rdata),
      .gpio_pad_out (gpio_pad_out)
   );

   timer_ctrl #(
      .timer_width (timer_width)
   ) u_timer (
      .clk         (clk),
      .rst_n       (rst_n),
      .bus_addr    (bus_addr),
      .bus_bytesel (bus_bytesel),
      .bus_din     (bus_din),
      .timer_en    (timer_en),
      .timer_rdata (timer_rdata),
      .timer_irq   (timer_irq)
   );

endmodule

// ==== verification/periph_checker.sv ====
`timescale 1ns/1ps

module periph_checker (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      bus_en,
   input  logic [3:0]                bus_bytesel,
   input  logic                      gpio_en,
   input  logic                      timer_en,
   input  logic                      timer_irq,
   input  logic                      timer_flag,
   input  periph_pkg::timer_state_t  timer_state
);

   import periph_pkg::*;

   // Bus write that lands in the timer
   logic timer_write;

   assign timer_write = timer_en && (|bus_bytesel);

   // Decoder never selects two peripherals at once
   one_enable: assert property (@(posedge clk) disable iff (rst_n)
      !(gpio_en && timer_en))
      else $error("gpio_en and timer_en are high in the same cycle");

   // Peripheral strobes only follow the bus strobe
   enable_needs_bus: assert property (@(posedge clk) disable iff (rst_n)
      (gpio_en || timer_en) |-> bus_en)
      else $error("peripheral enable is high while bus_en is low");

   // Interrupt level is the sticky flag itself
   irq_is_flag: assert property (@(posedge clk) disable iff (rst_n)
      timer_irq == timer_flag)
      else $error("timer_irq differs from the timer status flag");

   // Expired one-shot parks until software writes the timer
   expired_holds: assert property (@(posedge clk) disable iff (rst_n)
      (timer_state == tmr_expired) && !timer_write |=> timer_state == tmr_expired)
      else $error("timer left the expired state without a bus write");

endmodule

// Attach to every instance of the top level
bind periph_top periph_checker u_checker (
   .clk         (clk),
   .rst_n       (rst_n),
   .bus_en      (bus_en),
   .bus_bytesel (bus_bytesel),
   .gpio_en     (gpio_en),
   .timer_en    (timer_en),
   .timer_irq   (timer_irq),
   .timer_flag  (u_timer.flag_r),
   .timer_state (u_timer.state_r)
);

// ==== verification/periph_tb.sv ====
`timescale 1ns/1ps

module periph_tb;

   import periph_pkg::*;

   // Longest reload is 20, so 100 edges is plenty
   localparam int irq_timeout = 100;

   logic                       clk;
   logic                       rst_n;
   logic [periph_addr_msb:0]   bus_addr;
   logic [3:0]                 bus_bytesel;
   logic [31:0]                bus_din;
   logic                       bus_en;
   logic [31:0]                bus_dout;
   logic [31:0]                pad_gpio_in;
   logic [31:0]                gpio_pad_out;
   logic                       timer_irq;

   // Register file model
   logic [31:0]  model_gpio_out;
   logic [31:0]  model_pad_in;
   logic [31:0]  model_load;
   logic [31:0]  model_ctrl;
   logic [31:0]  model_count;
   logic         model_flag;
   timer_state_t model_state;

   integer seed;
   logic   checking;

   periph_top dut0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .bus_addr     (bus_addr),
      .bus_bytesel  (bus_bytesel),
      .bus_din      (bus_din),
      .bus_en       (bus_en),
      .bus_dout     (bus_dout),
      .pad_gpio_in  (pad_gpio_in),
      .gpio_pad_out (gpio_pad_out),
      .timer_irq    (timer_irq)
   );

   // 40 ns clock
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Byte lanes of data replace the old value where bytesel is set
   function automatic logic [31:0] lane_merge(input logic [31:0] old_val,
                                              input logic [31:0] data,
                                              input logic [3:0]  bytesel);
      logic [31:0] merged;
      merged = old_val;
      for (int b = 0; b < 4; b++) begin
         if (bytesel[b]) begin
            merged[b*8 +: 8] = data[b*8 +: 8];
         end
      end
      return merged;
   endfunction

   // Expected read value of any address, unmapped ones read zero
   function automatic logic [31:0] expected_read(input logic [periph_addr_msb:0] addr);
      periph_region_t region;
      logic [1:0]     offset;
      logic [31:0]    value;
      region = periph_region_t'(addr[periph_addr_msb:region_lsb]);
      offset = addr[3:2];
      value  = 32'h0;
      case (region)
         region_gpio: begin
            case (offset)
               gpio_reg_out: value = model_gpio_out;
               gpio_reg_in:  value = model_pad_in;
               default:      value = 32'h0;
            endcase
         end
         region_timer: begin
            case (offset)
               timer_reg_load:  value = model_load;
               timer_reg_ctrl:  value = model_ctrl;
               timer_reg_count: value = model_count;
               default:         value = {28'h0, model_state, 1'b0, model_flag};
            endcase
         end
         default: value = 32'h0;
      endcase
      return value;
   endfunction

   // Model side effects of a bus write
   function automatic void apply_write(input logic [periph_addr_msb:0] addr,
                                       input logic [3:0]  bytesel,
                                       input logic [31:0] data);
      periph_region_t region;
      logic [1:0]     offset;
      region = periph_region_t'(addr[periph_addr_msb:region_lsb]);
      offset = addr[3:2];
      if (region == region_gpio && offset == gpio_reg_out) begin
         model_gpio_out = lane_merge(model_gpio_out, data, bytesel);
      end
      if (region == region_timer) begin
         // Timer registers take the whole word
         case (offset)
            timer_reg_load: model_load = data;
            timer_reg_ctrl: begin
               model_ctrl = {30'h0, data[1:0]};
               if (data[0]) begin
                  model_state = tmr_run;
                  model_count = model_load;
               end
               else begin
                  model_state = tmr_idle;
               end
            end
            timer_reg_status: model_flag = 1'b0;
            default: model_count = model_count;
         endcase
      end
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("ERR %s expected 0x%08h got 0x%08h", name, expected, actual);
         $display("Result: FAILED");
         $fatal(1);
      end
   endtask

   // One access, starting 2 ns after an edge and ending 2 ns after the next
   task automatic bus_write(input logic [periph_addr_msb:0] addr,
                            input logic [3:0]  bytesel,
                            input logic [31:0] data);
      bus_addr    = addr;
      bus_bytesel = bytesel;
      bus_din     = data;
      bus_en      = 1'b1;
      @(posedge clk);
      #2;
      bus_en      = 1'b0;
      bus_bytesel = 4'h0;
      apply_write(addr, bytesel, data);
   endtask

   task automatic bus_read(input logic [periph_addr_msb:0] addr, output logic [31:0] data);
      bus_addr    = addr;
      bus_bytesel = 4'h0;
      bus_en      = 1'b1;
      @(posedge clk);
      #2;
      bus_en      = 1'b0;
      data        = bus_dout;
   endtask

   task automatic read_check(input logic [periph_addr_msb:0] addr);
      logic [31:0] expected;
      logic [31:0] data;
      expected = expected_read(addr);
      bus_read(addr, data);
      check_value("bus_dout", expected, data);
   endtask

   // Counts edges until the interrupt level is seen high
   task automatic wait_for_irq(output int edges);
      edges = 0;
      while (timer_irq !== 1'b1 && edges < irq_timeout) begin
         @(posedge clk);
         #2;
         edges++;
      end
      if (timer_irq !== 1'b1) begin
         $display("Timer interrupt never rose within %0d clock edges", irq_timeout);
         $display("Result: FAILED");
         $fatal(1);
      end
   endtask

   // Pads follow the modelled output register, checked mid-cycle
   always @(negedge clk) begin
      if (checking) begin
         check_value("gpio_pad_out", model_gpio_out, gpio_pad_out);
      end
   end

   initial begin
      int                       i;
      int                       n;
      int                       edges;
      logic [31:0]              rnd;
      logic [31:0]              data;
      logic [3:0]               bytesel;
      logic [periph_addr_msb:0] hole;
      seed           = 16;
      checking       = 1'b0;
      // rst_n high holds the design in reset
      rst_n          = 1'b1;
      bus_addr       = '0;
      bus_bytesel    = 4'h0;
      bus_din        = 32'h0;
      bus_en         = 1'b0;
      pad_gpio_in    = 32'h0;
      model_gpio_out = 32'h0;
      model_pad_in   = 32'h0;
      model_load     = 32'h0;
      model_ctrl     = 32'h0;
      model_count    = 32'h0;
      model_flag     = 1'b0;
      model_state    = tmr_idle;
      repeat (3) @(posedge clk);
      #2;
      rst_n    = 1'b0;
      checking = 1'b1;

      // Everything reads zero out of reset
      check_value("timer_irq", 32'h0, {31'h0, timer_irq});
      read_check(12'h000);
      read_check(12'h004);
      for (i = 0; i < 4; i++) begin
         read_check({4'h1, 4'h0, 2'(i), 2'b00});
      end

      // Random byte-lane writes to the output register
      for (i = 0; i < 12; i++) begin
         rnd     = $random(seed);
         data    = $random(seed);
         bytesel = rnd[3:0];
         if (bytesel == 4'h0) begin
            bytesel = 4'hf;
         end
         bus_write(12'h000, bytesel, data);
         read_check(12'h000);
      end

      // Pad levels through the synchronizer
      for (i = 0; i < 6; i++) begin
         data        = $random(seed);
         pad_gpio_in = data;
         repeat (3) @(posedge clk);
         #2;
         model_pad_in = data;
         read_check(12'h004);
      end

      // One-shot, irq due N+1 edges after the enabling write
      rnd = $random(seed);
      n   = 2 + int'(rnd % 19);
      bus_write(12'h100, 4'hf, 32'(n));
      read_check(12'h100);
      bus_write(12'h104, 4'hf, 32'h1);
      wait_for_irq(edges);
      check_value("timer_irq edges", 32'(n + 1), 32'(edges));
      model_flag  = 1'b1;
      model_state = tmr_expired;
      read_check(12'h10C);
      bus_write(12'h10C, 4'hf, 32'h1);
      check_value("timer_irq", 32'h0, {31'h0, timer_irq});
      read_check(12'h10C);

      // Auto-reload, period is N+1 edges
      rnd = $random(seed);
      n   = 2 + int'(rnd % 19);
      bus_write(12'h100, 4'hf, 32'(n));
      bus_write(12'h104, 4'hf, 32'h3);
      wait_for_irq(edges);
      check_value("timer_irq edges", 32'(n + 1), 32'(edges));
      model_flag = 1'b1;
      // Clear costs one edge of the next period
      bus_write(12'h10C, 4'hf, 32'h1);
      check_value("timer_irq", 32'h0, {31'h0, timer_irq});
      wait_for_irq(edges);
      check_value("timer_irq period", 32'(n + 1), 32'(edges + 1));
      model_flag = 1'b1;
      bus_write(12'h104, 4'hf, 32'h0);
      read_check(12'h10C);
      bus_write(12'h10C, 4'hf, 32'h1);
      read_check(12'h10C);
      read_check(12'h104);

      // Unmapped holes swallow writes and read zero
      for (i = 0; i < 4; i++) begin
         hole = {4'(2 + 4 * i), 4'h0, 2'(i), 2'b00};
         data = $random(seed);
         bus_write(hole, 4'hf, data);
         read_check(hole);
      end
      read_check(12'h000);
      read_check(12'h100);

      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== sources.f ====
design/periph_pkg.sv
design/periph_bus_decoder.sv
design/gpio_ctrl.sv
design/timer_ctrl.sv
design/periph_top.sv
verification/periph_checker.sv
verification/periph_tb.sv

// ==== Makefile ====
# Verilator build and run for the peripheral subsystem

VERILATOR  ?= verilator
TOP        ?= periph_tb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
